/* rtl/fe_isa_pkg.sv */
`default_nettype none

package fe_isa_pkg;

    typedef logic [31:0] inst_word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;

    // register usage class of one instruction
    typedef enum logic [2:0] {
        REG_TYPE_I,
        REG_TYPE_RW,
        REG_TYPE_RRW,
        REG_TYPE_W,
        REG_TYPE_RR,
        REG_TYPE_BL,
        REG_TYPE_CSRXCHG
    } reg_type_e;

    // major opcode sits in the top six bits
    localparam int OPCODE_LSB = 26;

    localparam opcode_t OP_ALU3R  = 6'b000000;
    localparam opcode_t OP_CSR    = 6'b000001;
    localparam opcode_t OP_ALU2RI = 6'b000010;
    localparam opcode_t OP_LU12I  = 6'b000101;
    localparam opcode_t OP_LOAD   = 6'b001010;
    localparam opcode_t OP_JIRL   = 6'b010011;
    localparam opcode_t OP_BL     = 6'b010101;
    localparam opcode_t OP_BEQ    = 6'b010110;
    localparam opcode_t OP_BNE    = 6'b010111;

    // register field positions
    localparam int RD_LSB = 0;
    localparam int RJ_LSB = 5;
    localparam int RK_LSB = 10;

    // link register written by bl
    localparam reg_idx_t REG_RA = 5'd1;

    localparam reg_idx_t REG_ZERO = 5'd0;

endpackage

`default_nettype wire

/* rtl/fe_cfg_pkg.sv */
`default_nettype none

package fe_cfg_pkg;

    // byte address of an instruction
    typedef logic [31:0] pc_t;

    // apb read data
    typedef logic [31:0] apb_data_t;

    // one fetch unit is an aligned pair of words
    localparam pc_t PAIR_BYTES = 32'd8;

    // apb fetch sequencing
    typedef enum logic [1:0] {
        FS_IDLE,
        FS_SETUP,
        FS_ACCESS,
        FS_PUSH
    } fetch_state_e;

endpackage

`default_nettype wire

/* rtl/fetch_pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen #(
    parameter fe_cfg_pkg::pc_t RESET_PC = 32'h0000_1000
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            redirect_valid_i,
    input  fe_cfg_pkg::pc_t redirect_pc_i,
    input  logic            pair_take_i,
    output fe_cfg_pkg::pc_t pair_addr_o,
    output logic [1:0]      slot_mask_o
);

    localparam fe_cfg_pkg::pc_t PAIR_MASK = ~(fe_cfg_pkg::PAIR_BYTES - 32'd1);

    fe_cfg_pkg::pc_t pair_addr_q;
    logic [1:0]      slot_mask_q;

    // redirect wins over a sequential step
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pair_addr_q <= RESET_PC & PAIR_MASK;
            slot_mask_q <= 2'b11;
        end else if (redirect_valid_i) begin
            pair_addr_q <= redirect_pc_i & PAIR_MASK;
            // odd word target skips slot 0
            slot_mask_q <= {1'b1, ~redirect_pc_i[2]};
        end else if (pair_take_i) begin
            pair_addr_q <= pair_addr_q + fe_cfg_pkg::PAIR_BYTES;
            slot_mask_q <= 2'b11;
        end
    end

    assign pair_addr_o = pair_addr_q;
    assign slot_mask_o = slot_mask_q;

endmodule

`default_nettype wire

/* rtl/apb_fetch_master.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_fetch_master (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  fe_cfg_pkg::pc_t               pair_addr_i,
    input  logic [1:0]                    slot_mask_i,
    input  fe_cfg_pkg::apb_data_t         prdata_i,
    input  logic                          pready_i,
    input  logic                          push_ready_i,
    output logic                          pair_take_o,
    output fe_cfg_pkg::pc_t               paddr_o,
    output logic                          psel_o,
    output logic                          penable_o,
    output logic                          push_valid_o,
    output logic [1:0]                    push_num_o,
    output fe_isa_pkg::inst_word_t [1:0]  push_word_o,
    output fe_cfg_pkg::pc_t [1:0]         push_pc_o
);

    fe_cfg_pkg::fetch_state_e state_q;
    fe_cfg_pkg::fetch_state_e state_d;

    fe_cfg_pkg::pc_t              word_addr_q;
    logic                         more_q;
    logic                         stale_q;
    logic [1:0]                   cnt_q;
    fe_isa_pkg::inst_word_t [1:0] words_q;
    fe_cfg_pkg::pc_t [1:0]        pcs_q;
    logic                         beat_done;

    assign beat_done = (state_q == fe_cfg_pkg::FS_ACCESS) && pready_i;

    always_comb begin
        state_d     = state_q;
        pair_take_o = 1'b0;
        case (state_q)
            fe_cfg_pkg::FS_IDLE: begin
                // never latch a pair that the redirect is replacing
                if (!flush_i) begin
                    pair_take_o = 1'b1;
                    state_d     = fe_cfg_pkg::FS_SETUP;
                end
            end
            fe_cfg_pkg::FS_SETUP: begin
                state_d = fe_cfg_pkg::FS_ACCESS;
            end
            fe_cfg_pkg::FS_ACCESS: begin
                if (pready_i) begin
                    if (stale_q || flush_i) begin
                        state_d = fe_cfg_pkg::FS_IDLE;
                    end else if (more_q) begin
                        state_d = fe_cfg_pkg::FS_SETUP;
                    end else begin
                        state_d = fe_cfg_pkg::FS_PUSH;
                    end
                end
            end
            fe_cfg_pkg::FS_PUSH: begin
                if (flush_i || push_ready_i) begin
                    state_d = fe_cfg_pkg::FS_IDLE;
                end
            end
            default: begin
                state_d = fe_cfg_pkg::FS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= fe_cfg_pkg::FS_IDLE;
            word_addr_q <= '0;
            more_q      <= 1'b0;
            stale_q     <= 1'b0;
            cnt_q       <= 2'd0;
        end else begin
            state_q <= state_d;
            if (state_q == fe_cfg_pkg::FS_IDLE) begin
                stale_q <= 1'b0;
            end else if (flush_i) begin
                stale_q <= 1'b1;
            end
            if (pair_take_o) begin
                // start at the first word the mask keeps
                word_addr_q <= {pair_addr_i[31:3], ~slot_mask_i[0], 2'b00};
                more_q      <= &slot_mask_i;
                cnt_q       <= 2'd0;
            end else if (beat_done) begin
                word_addr_q <= word_addr_q | 32'd4;
                more_q      <= 1'b0;
                cnt_q       <= cnt_q + 2'd1;
            end
        end
    end

    // words are compacted into slot 0 upwards
    always_ff @(posedge clk) begin
        if (beat_done) begin
            words_q[cnt_q[0]] <= prdata_i;
            pcs_q[cnt_q[0]]   <= word_addr_q;
        end
    end

    assign paddr_o   = word_addr_q;
    assign psel_o    = (state_q == fe_cfg_pkg::FS_SETUP) || (state_q == fe_cfg_pkg::FS_ACCESS);
    assign penable_o = (state_q == fe_cfg_pkg::FS_ACCESS);

    assign push_valid_o = (state_q == fe_cfg_pkg::FS_PUSH);
    assign push_num_o   = cnt_q;
    assign push_word_o  = words_q;
    assign push_pc_o    = pcs_q;

endmodule

`default_nettype wire

/* rtl/multi_channel_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module multi_channel_fifo #(
    parameter int FIFO_DEPTH = 8,
    parameter int DATA_WIDTH = 64
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       flush_i,
    input  logic [1:0]                 write_num_i,
    input  logic [1:0][DATA_WIDTH-1:0] write_data_i,
    input  logic                       read_ready_i,
    input  logic [1:0]                 read_num_i,
    output logic                       write_ready_o,
    output logic [1:0]                 read_valid_o,
    output logic [1:0][DATA_WIDTH-1:0] read_data_o
);

    localparam int AW         = $clog2(FIFO_DEPTH);
    localparam int CW         = AW + 1;
    localparam int BANK_DEPTH = FIFO_DEPTH / 2;

    // even entries in bank 0, odd entries in bank 1
    logic [DATA_WIDTH-1:0] bank_mem [2][BANK_DEPTH];

    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;

    logic [1:0]            push_num;
    logic [1:0]            pop_num;
    logic [AW-1:0]         wr_idx     [2];
    logic [AW-1:0]         rd_idx     [2];
    logic                  bank_we    [2];
    logic [AW-2:0]         bank_row   [2];
    logic [DATA_WIDTH-1:0] bank_wdata [2];

    assign write_ready_o   = (count_q <= CW'(FIFO_DEPTH - 2));
    assign read_valid_o[0] = (count_q >= CW'(1));
    assign read_valid_o[1] = (count_q >= CW'(2));

    assign push_num = write_ready_o ? write_num_i : 2'd0;
    assign pop_num  = read_ready_i ? read_num_i : 2'd0;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            wr_idx[i]      = wr_ptr_q + AW'(i);
            rd_idx[i]      = rd_ptr_q + AW'(i);
            read_data_o[i] = bank_mem[rd_idx[i][0]][rd_idx[i][AW-1:1]];
        end
        // consecutive entries always land in different banks
        for (int b = 0; b < 2; b++) begin
            if (wr_ptr_q[0] == b[0]) begin
                bank_we[b]    = !flush_i && (push_num >= 2'd1);
                bank_row[b]   = wr_idx[0][AW-1:1];
                bank_wdata[b] = write_data_i[0];
            end else begin
                bank_we[b]    = !flush_i && (push_num >= 2'd2);
                bank_row[b]   = wr_idx[1][AW-1:1];
                bank_wdata[b] = write_data_i[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (bank_we[b]) begin
                bank_mem[b][bank_row[b]] <= bank_wdata[b];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + AW'(push_num);
            rd_ptr_q <= rd_ptr_q + AW'(pop_num);
            count_q  <= count_q + CW'(push_num) - CW'(pop_num);
        end
    end

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  fe_isa_pkg::inst_word_t inst_i,
    output fe_isa_pkg::reg_type_e  reg_type_o,
    output fe_isa_pkg::reg_idx_t   r_reg0_o,
    output fe_isa_pkg::reg_idx_t   r_reg1_o,
    output fe_isa_pkg::reg_idx_t   w_reg_o
);

    fe_isa_pkg::opcode_t  opcode;
    fe_isa_pkg::reg_idx_t rd;
    fe_isa_pkg::reg_idx_t rj;
    fe_isa_pkg::reg_idx_t rk;

    assign opcode = inst_i[fe_isa_pkg::OPCODE_LSB +: $bits(fe_isa_pkg::opcode_t)];
    assign rd     = inst_i[fe_isa_pkg::RD_LSB +: $bits(fe_isa_pkg::reg_idx_t)];
    assign rj     = inst_i[fe_isa_pkg::RJ_LSB +: $bits(fe_isa_pkg::reg_idx_t)];
    assign rk     = inst_i[fe_isa_pkg::RK_LSB +: $bits(fe_isa_pkg::reg_idx_t)];

    // class from the major opcode
    always_comb begin
        case (opcode)
            fe_isa_pkg::OP_ALU3R:  reg_type_o = fe_isa_pkg::REG_TYPE_RRW;
            fe_isa_pkg::OP_CSR:    reg_type_o = fe_isa_pkg::REG_TYPE_CSRXCHG;
            fe_isa_pkg::OP_ALU2RI: reg_type_o = fe_isa_pkg::REG_TYPE_RW;
            fe_isa_pkg::OP_LU12I:  reg_type_o = fe_isa_pkg::REG_TYPE_W;
            fe_isa_pkg::OP_LOAD:   reg_type_o = fe_isa_pkg::REG_TYPE_RW;
            fe_isa_pkg::OP_JIRL:   reg_type_o = fe_isa_pkg::REG_TYPE_RW;
            fe_isa_pkg::OP_BL:     reg_type_o = fe_isa_pkg::REG_TYPE_BL;
            fe_isa_pkg::OP_BEQ:    reg_type_o = fe_isa_pkg::REG_TYPE_RR;
            fe_isa_pkg::OP_BNE:    reg_type_o = fe_isa_pkg::REG_TYPE_RR;
            default:               reg_type_o = fe_isa_pkg::REG_TYPE_I;
        endcase
    end

    // register fields by class
    always_comb begin
        r_reg0_o = fe_isa_pkg::REG_ZERO;
        r_reg1_o = fe_isa_pkg::REG_ZERO;
        w_reg_o  = fe_isa_pkg::REG_ZERO;
        case (reg_type_o)
            fe_isa_pkg::REG_TYPE_RRW: begin
                r_reg0_o = rk;
                r_reg1_o = rj;
                w_reg_o  = rd;
            end
            fe_isa_pkg::REG_TYPE_RW: begin
                r_reg1_o = rj;
                w_reg_o  = rd;
            end
            fe_isa_pkg::REG_TYPE_W: begin
                w_reg_o = rd;
            end
            // branches compare rd against rj
            fe_isa_pkg::REG_TYPE_RR: begin
                r_reg0_o = rd;
                r_reg1_o = rj;
            end
            fe_isa_pkg::REG_TYPE_BL: begin
                w_reg_o = fe_isa_pkg::REG_RA;
            end
            // csrxchg reads and writes rd
            fe_isa_pkg::REG_TYPE_CSRXCHG: begin
                r_reg0_o = rd;
                r_reg1_o = rj;
                w_reg_o  = rd;
            end
            default: begin
                r_reg0_o = fe_isa_pkg::REG_ZERO;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend #(
    parameter fe_cfg_pkg::pc_t RESET_PC   = 32'h0000_1000,
    parameter int              FIFO_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         arst_n_i,
    // instruction memory bus
    output fe_cfg_pkg::pc_t              paddr_o,
    output logic                         psel_o,
    output logic                         penable_o,
    output logic                         pwrite_o,
    input  fe_cfg_pkg::apb_data_t        prdata_i,
    input  logic                         pready_i,
    input  logic                         pslverr_i,
    // redirect from backend
    input  logic                         redirect_valid_i,
    input  fe_cfg_pkg::pc_t              redirect_pc_i,
    // issue handshake
    input  logic [1:0]                   issue_num_i,
    input  logic                         backend_stall_i,
    output logic [1:0]                   inst_valid_o,
    output fe_cfg_pkg::pc_t [1:0]        inst_pc_o,
    output fe_isa_pkg::inst_word_t [1:0] inst_word_o,
    output fe_isa_pkg::reg_type_e [1:0]  reg_type_o,
    output fe_isa_pkg::reg_idx_t [1:0]   r_reg0_o,
    output fe_isa_pkg::reg_idx_t [1:0]   r_reg1_o,
    output fe_isa_pkg::reg_idx_t [1:0]   w_reg_o
);

    localparam int WORD_W  = $bits(fe_isa_pkg::inst_word_t);
    localparam int PC_W    = $bits(fe_cfg_pkg::pc_t);
    localparam int ENTRY_W = WORD_W + PC_W;

    logic                         fe_flush;
    fe_cfg_pkg::pc_t              pair_addr;
    logic [1:0]                   slot_mask;
    logic                         pair_take;
    logic                         push_valid;
    logic [1:0]                   push_num;
    fe_isa_pkg::inst_word_t [1:0] push_word;
    fe_cfg_pkg::pc_t [1:0]        push_pc;
    logic                         fifo_write_ready;
    logic [1:0]                   fifo_write_num;
    logic [1:0][ENTRY_W-1:0]      fifo_wdata;
    logic [1:0][ENTRY_W-1:0]      fifo_rdata;

    // slave errors are not handled in the fetch path
    assign fe_flush = redirect_valid_i;
    assign pwrite_o = 1'b0;

    fetch_pc_gen #(
        .RESET_PC(RESET_PC)
    ) u_pc_gen (
        .clk,
        .arst_n_i,
        .redirect_valid_i,
        .redirect_pc_i,
        .pair_take_i (pair_take),
        .pair_addr_o (pair_addr),
        .slot_mask_o (slot_mask)
    );

    apb_fetch_master u_fetch (
        .clk,
        .arst_n_i,
        .flush_i      (fe_flush),
        .pair_addr_i  (pair_addr),
        .slot_mask_i  (slot_mask),
        .prdata_i,
        .pready_i,
        .push_ready_i (fifo_write_ready),
        .pair_take_o  (pair_take),
        .paddr_o,
        .psel_o,
        .penable_o,
        .push_valid_o (push_valid),
        .push_num_o   (push_num),
        .push_word_o  (push_word),
        .push_pc_o    (push_pc)
    );

    // entry layout is pc above word
    assign fifo_write_num = push_valid ? push_num : 2'd0;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            fifo_wdata[s]  = {push_pc[s], push_word[s]};
            inst_pc_o[s]   = fifo_rdata[s][ENTRY_W-1:WORD_W];
            inst_word_o[s] = fifo_rdata[s][WORD_W-1:0];
        end
    end

    multi_channel_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .DATA_WIDTH (ENTRY_W)
    ) u_inst_fifo (
        .clk,
        .arst_n_i,
        .flush_i       (fe_flush),
        .write_num_i   (fifo_write_num),
        .write_data_i  (fifo_wdata),
        .read_ready_i  (~backend_stall_i),
        .read_num_i    (issue_num_i),
        .write_ready_o (fifo_write_ready),
        .read_valid_o  (inst_valid_o),
        .read_data_o   (fifo_rdata)
    );

    // one decoder per read slot
    for (genvar s = 0; s < 2; s++) begin : g_dec
        inst_decoder u_dec (
            .inst_i     (inst_word_o[s]),
            .reg_type_o (reg_type_o[s]),
            .r_reg0_o   (r_reg0_o[s]),
            .r_reg1_o   (r_reg1_o[s]),
            .w_reg_o    (w_reg_o[s])
        );
    end

endmodule

`default_nettype wire

/* verif/apb_inst_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_inst_mem #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  fe_cfg_pkg::pc_t       paddr_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    output fe_cfg_pkg::apb_data_t prdata_o,
    output logic                  pready_o
);

    localparam int AW = $clog2(MEM_WORDS);

    fe_cfg_pkg::apb_data_t mem [MEM_WORDS];
    logic [1:0]            wait_q;

    // word index wraps on the memory size
    assign prdata_o = mem[paddr_i[AW+1:2]];
    assign pready_o = psel_i && penable_i && (wait_q == 2'd0);

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_q <= 2'd0;
        end else if (psel_i && !penable_i) begin
            // fresh wait count in every setup cycle
            wait_q <= 2'($urandom_range(3));
        end else if (psel_i && penable_i && (wait_q != 2'd0)) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    task automatic write_word(input logic [AW-1:0] idx, input fe_cfg_pkg::apb_data_t data);
        mem[idx] = data;
    endtask

endmodule

`default_nettype wire

/* verif/frontend_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_asserts (
    input logic            clk,
    input logic            arst_n_i,
    input logic            psel_i,
    input logic            penable_i,
    input fe_cfg_pkg::pc_t paddr_i,
    input logic            pready_i,
    input logic [1:0]      issue_num_i,
    input logic [1:0]      inst_valid_i
);

    logic [1:0] valid_count;

    assign valid_count = {1'b0, inst_valid_i[0]} + {1'b0, inst_valid_i[1]};

    // address phase holds until the slave completes the transfer
    a_psel_hold: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (psel_i && !(penable_i && pready_i)) |=> (psel_i && $stable(paddr_i))
    ) else $error("psel dropped or paddr changed before pready");

    a_enable_after_setup: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $rose(penable_i) |-> $past(psel_i && !penable_i)
    ) else $error("penable rose without a preceding setup cycle");

    a_issue_bound: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        issue_num_i <= valid_count
    ) else $error("backend issued more instructions than were valid");

    // slots fill from slot 0 upwards
    a_valid_order: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        inst_valid_i[1] |-> inst_valid_i[0]
    ) else $error("slot 1 valid while slot 0 is empty");

endmodule

`default_nettype wire

/* verif/frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

    localparam fe_cfg_pkg::pc_t RESET_PC = 32'h0000_1000;
    localparam int FIFO_DEPTH   = 8;
    localparam int SEED         = 78;
    localparam int RESET_CYCLES = 4;
    localparam int MEM_WORDS    = 1024;
    localparam int NUM_INSTS    = 3000;
    // roughly nine cycles per fetched pair, with margin for stalls and redirects
    localparam int MAX_CYCLES   = NUM_INSTS * 13 + 1000;

    localparam logic [5:0] FORCED_OPS [9] = '{
        6'b000000, 6'b000001, 6'b000010, 6'b000101, 6'b001010,
        6'b010011, 6'b010101, 6'b010110, 6'b010111
    };

    logic                         clk;
    logic                         arst_n;
    fe_cfg_pkg::pc_t              paddr;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    fe_cfg_pkg::apb_data_t        prdata;
    logic                         pready;
    logic                         pslverr;
    logic                         redirect_valid;
    fe_cfg_pkg::pc_t              redirect_pc;
    logic [1:0]                   issue_num;
    logic                         backend_stall;
    logic [1:0]                   inst_valid;
    fe_cfg_pkg::pc_t [1:0]        inst_pc;
    fe_isa_pkg::inst_word_t [1:0] inst_word;
    fe_isa_pkg::reg_type_e [1:0]  reg_type;
    fe_isa_pkg::reg_idx_t [1:0]   r_reg0;
    fe_isa_pkg::reg_idx_t [1:0]   r_reg1;
    fe_isa_pkg::reg_idx_t [1:0]   w_reg;

    fe_isa_pkg::inst_word_t mem_model [MEM_WORDS];
    fe_cfg_pkg::pc_t        exp_pc;
    int                     cycle_count = 0;

    frontend #(
        .RESET_PC   (RESET_PC),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .clk              (clk),
        .arst_n_i         (arst_n),
        .paddr_o          (paddr),
        .psel_o           (psel),
        .penable_o        (penable),
        .pwrite_o         (pwrite),
        .prdata_i         (prdata),
        .pready_i         (pready),
        .pslverr_i        (pslverr),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .issue_num_i      (issue_num),
        .backend_stall_i  (backend_stall),
        .inst_valid_o     (inst_valid),
        .inst_pc_o        (inst_pc),
        .inst_word_o      (inst_word),
        .reg_type_o       (reg_type),
        .r_reg0_o         (r_reg0),
        .r_reg1_o         (r_reg1),
        .w_reg_o          (w_reg)
    );

    apb_inst_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) imem0 (
        .clk       (clk),
        .arst_n_i  (arst_n),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .prdata_o  (prdata),
        .pready_o  (pready)
    );

    bind frontend frontend_asserts u_asserts (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .psel_i       (psel_o),
        .penable_i    (penable_o),
        .paddr_i      (paddr_o),
        .pready_i     (pready_i),
        .issue_num_i  (issue_num_i),
        .inst_valid_i (inst_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: instruction stream stalled");
            $display("RESULT: FAIL");
            $fatal(1, "cycle limit of %0d reached", MAX_CYCLES);
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("ERR %s expected 0x%08h actual 0x%08h", name, exp_val, act_val);
        $display("RESULT: FAIL");
        $fatal(1, "value mismatch in %s", name);
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[10'(i)] = $urandom();
        end
        // every decoded major opcode sits right at the reset pc
        for (int k = 0; k < 9; k++) begin
            mem_model[10'(k)][31:26] = FORCED_OPS[4'(k)];
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem0.write_word(10'(i), mem_model[10'(i)]);
        end
    endtask

    // reference register usage table
    task automatic expected_regs(
        input  fe_isa_pkg::inst_word_t word,
        output fe_isa_pkg::reg_type_e  rtype,
        output fe_isa_pkg::reg_idx_t   r0,
        output fe_isa_pkg::reg_idx_t   r1,
        output fe_isa_pkg::reg_idx_t   wr
    );
        case (word[31:26])
            6'b000000: rtype = fe_isa_pkg::REG_TYPE_RRW;
            6'b000001: rtype = fe_isa_pkg::REG_TYPE_CSRXCHG;
            6'b000010: rtype = fe_isa_pkg::REG_TYPE_RW;
            6'b000101: rtype = fe_isa_pkg::REG_TYPE_W;
            6'b001010: rtype = fe_isa_pkg::REG_TYPE_RW;
            6'b010011: rtype = fe_isa_pkg::REG_TYPE_RW;
            6'b010101: rtype = fe_isa_pkg::REG_TYPE_BL;
            6'b010110: rtype = fe_isa_pkg::REG_TYPE_RR;
            6'b010111: rtype = fe_isa_pkg::REG_TYPE_RR;
            default:   rtype = fe_isa_pkg::REG_TYPE_I;
        endcase
        r0 = 5'd0;
        r1 = 5'd0;
        wr = 5'd0;
        case (rtype)
            fe_isa_pkg::REG_TYPE_RRW: begin
                r0 = word[14:10];
                r1 = word[9:5];
                wr = word[4:0];
            end
            fe_isa_pkg::REG_TYPE_RW: begin
                r1 = word[9:5];
                wr = word[4:0];
            end
            fe_isa_pkg::REG_TYPE_W: begin
                wr = word[4:0];
            end
            fe_isa_pkg::REG_TYPE_RR: begin
                r0 = word[4:0];
                r1 = word[9:5];
            end
            fe_isa_pkg::REG_TYPE_BL: begin
                wr = 5'd1;
            end
            fe_isa_pkg::REG_TYPE_CSRXCHG: begin
                r0 = word[4:0];
                r1 = word[9:5];
                wr = word[4:0];
            end
            default: begin
                wr = 5'd0;
            end
        endcase
    endtask

    task automatic check_quiet(input string phase);
        assert (!psel && !penable && (inst_valid == 2'b00))
            else report_failure($sformatf("%s: bus or issue outputs active", phase));
    endtask

    task automatic check_issued_slot(input logic slot);
        fe_isa_pkg::inst_word_t word;
        fe_isa_pkg::reg_type_e  exp_type;
        fe_isa_pkg::reg_idx_t   exp_r0;
        fe_isa_pkg::reg_idx_t   exp_r1;
        fe_isa_pkg::reg_idx_t   exp_w;
        word = mem_model[exp_pc[11:2]];
        expected_regs(word, exp_type, exp_r0, exp_r1, exp_w);
        assert (inst_pc[slot] == exp_pc)
            else report_mismatch($sformatf("stream slot%0d pc", slot), exp_pc, inst_pc[slot]);
        assert (inst_word[slot] == word)
            else report_mismatch($sformatf("stream slot%0d word", slot), word, inst_word[slot]);
        assert (reg_type[slot] == exp_type)
            else report_mismatch($sformatf("decode slot%0d type", slot),
                                 32'(exp_type), 32'(reg_type[slot]));
        assert (r_reg0[slot] == exp_r0)
            else report_mismatch($sformatf("decode slot%0d r_reg0", slot),
                                 32'(exp_r0), 32'(r_reg0[slot]));
        assert (r_reg1[slot] == exp_r1)
            else report_mismatch($sformatf("decode slot%0d r_reg1", slot),
                                 32'(exp_r1), 32'(r_reg1[slot]));
        assert (w_reg[slot] == exp_w)
            else report_mismatch($sformatf("decode slot%0d w_reg", slot),
                                 32'(exp_w), 32'(w_reg[slot]));
        exp_pc = exp_pc + 32'd4;
    endtask

    initial begin
        int              issued;
        int              nvalid;
        int              avail;
        int              next_issue;
        int              stall_run;
        logic            next_stall;
        logic            next_redirect;
        fe_cfg_pkg::pc_t next_pc;
        logic            expect_empty;
        arst_n         = 1'b0;
        pslverr        = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        issue_num      = 2'd0;
        backend_stall  = 1'b0;
        issued         = 0;
        stall_run      = 0;
        expect_empty   = 1'b0;
        exp_pc         = RESET_PC;
        void'($urandom(SEED));
        fill_memory();

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            check_quiet("during reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_quiet("first cycle after reset");

        while (issued < NUM_INSTS) begin
            @(negedge clk);
            if (expect_empty) begin
                assert (inst_valid == 2'b00)
                    else report_failure("instructions still valid in the cycle after a redirect");
            end
            // instruction memory is read only
            assert (!pwrite)
                else report_failure("write strobe raised on the instruction bus");
            expect_empty = redirect_valid;
            nvalid = int'(inst_valid[0]) + int'(inst_valid[1]);
            avail  = nvalid;
            if (redirect_valid) begin
                exp_pc = redirect_pc;
                avail  = 0;
            end else if (!backend_stall) begin
                for (int s = 0; s < int'(issue_num); s++) begin
                    check_issued_slot(1'(s));
                    issued++;
                end
                avail = nvalid - int'(issue_num);
            end

            // next cycle holds at least what is left after this pop
            if (stall_run > 0) begin
                stall_run--;
                next_stall = 1'b1;
            end else if ($urandom_range(63) == 0) begin
                stall_run  = 20 + int'($urandom_range(60));
                next_stall = 1'b1;
            end else begin
                next_stall = ($urandom_range(3) == 0);
            end
            next_pc       = RESET_PC + 32'($urandom_range(MEM_WORDS - 1) * 4);
            next_redirect = ($urandom_range(149) == 0);
            next_issue    = next_redirect ? 0 : int'($urandom_range(avail));

            @(posedge clk);
            backend_stall  <= next_stall;
            issue_num      <= 2'(next_issue);
            redirect_valid <= next_redirect;
            redirect_pc    <= next_pc;
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* frontend.f */
rtl/fe_isa_pkg.sv
rtl/fe_cfg_pkg.sv
rtl/fetch_pc_gen.sv
rtl/apb_fetch_master.sv
rtl/multi_channel_fifo.sv
rtl/inst_decoder.sv
rtl/frontend.sv
verif/apb_inst_mem.sv
verif/frontend_asserts.sv
verif/frontend_tb.sv

/* Makefile */
# Verilator build for the instruction frontend testbench

VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= frontend.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard rtl/*.sv) $(wildcard verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# a failing run ends in $fatal, so the exit status carries the result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
